// ==== include/main_settings.svh ====
// board-wide sizes; player count must stay within 1..3 since cabinet read code 3 is the last slot
`ifndef MAIN_SETTINGS_SVH
`define MAIN_SETTINGS_SVH

// work RAM address width, 4 KB on the board
`define MAIN_RAM_AW 12

// joystick players wired to the cabinet read
// slot 0 is the system byte, slots 1..3 are players
`define MAIN_NUM_PLAYERS 2

// flops between a cabinet switch and the read path
`define MAIN_SYNC_STAGES 2

`endif

// ==== source/main_pkg.sv ====
// bus and cabinet types only; switch payloads are active low as they come from the cabinet
`default_nettype none

package main_pkg;

    // one CPU bus cycle as seen on the board
    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;   // 1 = read
        logic        vma;   // valid memory access
        logic [7:0]  dout;  // CPU write data
    } cpu_bus_t;

    // one bit per decoded region
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic vscr;
        logic obj;
        logic color;
        logic iow;
        logic snd_data;
        logic snd_on;
        logic ior;
        logic in5;      // dipsw_b
        logic in6;      // dipsw_a
    } chip_sel_t;

    // raw joystick lines, active low
    // 5:4 buttons, 3:0 directions in harness order
    typedef struct packed {
        logic [6:0] joy;
    } player_t;

    // system switches, active low
    typedef struct packed {
        logic [1:0] start;
        logic       service;
        logic [1:0] coin;
    } sys_sw_t;

endpackage

`default_nettype wire

// ==== source/main_bus_decoder.sv ====
// purely combinational; at most one select per cycle and none without vma, ROM decodes reads only
`default_nettype none

module main_bus_decoder (
    input  main_pkg::cpu_bus_t  cpu_bus,
    output main_pkg::chip_sel_t sel
);

    logic [15:0] a;

    assign a = cpu_bus.addr;

    always_comb begin
        sel = '0;
        if (cpu_bus.vma) begin
            // 6000-ffff, board only gates reads onto the ROM
            sel.rom = cpu_bus.rnw && (a[15:13] > 3'd2);
            if (a[15:12] == 4'h2) begin
                sel.ram = 1'b1;     // 2000-2fff
            end
            if (a[15:11] == 5'b0_0110) begin
                sel.vram = 1'b1;    // 3000-37ff
            end
            // 3c00 page, 128-byte blocks
            if (a[15:10] == 6'b00_1111) begin
                case (a[9:7])
                    3'd0: begin
                        // 16-byte blocks in the first 128
                        case (a[6:4])
                            3'd2:    sel.color = 1'b1;  // 3c20
                            3'd3:    sel.vscr  = 1'b1;  // 3c30
                            default: ;                  // watchdog and unused
                        endcase
                    end
                    3'd1: sel.iow      = 1'b1;  // 3c80
                    3'd2: sel.snd_data = 1'b1;  // 3d00
                    3'd3: sel.snd_on   = 1'b1;  // 3d80
                    3'd4: sel.ior      = 1'b1;  // 3e00
                    3'd5: sel.in5      = 1'b1;  // 3e80
                    3'd6: sel.in6      = 1'b1;  // 3f00
                    3'd7: sel.obj      = 1'b1;  // 3f80
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cabinet_sync.sv ====
// payload delayed by MAIN_SYNC_STAGES clocks; resets to all ones, i.e. released for active-low switches
`default_nettype none

`include "main_settings.svh"

module cabinet_sync #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      rst,
    input  payload_t din,
    output payload_t dout
);

    payload_t stages [`MAIN_SYNC_STAGES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MAIN_SYNC_STAGES; i++) begin
                stages[i] <= '1;
            end
        end else begin
            stages[0] <= din;   // first flop sees the async switch
            for (int i = 1; i < `MAIN_SYNC_STAGES; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[`MAIN_SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== source/main_ctrl_irq.sv ====
// writes only land with cpu_cen high; irq_n cannot be set while the clear latch holds 0
`default_nettype none

module main_ctrl_irq (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cpu_cen,
    input  main_pkg::cpu_bus_t  cpu_bus,
    input  main_pkg::chip_sel_t sel,
    input  wire                 lvbl,
    input  wire                 dip_pause,
    output logic                flip,
    output logic                objche,
    output logic                irq_n,
    output logic [3:0]          pal_sel
);

    logic wr_cycle;
    logic irq_clr;      // 0 holds the interrupt released
    logic irq_trig;
    logic irq_trig_l;

    assign wr_cycle = cpu_cen && !cpu_bus.rnw;
    assign irq_trig = ~lvbl & dip_pause;   // pause switch masks vblank

    // board control latches
    always_ff @(posedge clk) begin
        if (rst) begin
            flip    <= 1'b0;
            objche  <= 1'b0;
            irq_clr <= 1'b0;
            pal_sel <= 4'd0;
        end else if (wr_cycle) begin
            if (sel.iow) begin
                objche  <= cpu_bus.dout[5];
                irq_clr <= cpu_bus.dout[1];
                flip    <= cpu_bus.dout[0];
            end
            if (sel.color) begin
                pal_sel <= cpu_bus.dout[3:0];
            end
        end
    end

    // vblank interrupt flip-flop, clear wins over set
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_trig_l <= 1'b0;
            irq_n      <= 1'b1;
        end else begin
            irq_trig_l <= irq_trig;
            if (!irq_clr) begin
                irq_n <= 1'b1;
            end else if (irq_trig && !irq_trig_l) begin
                irq_n <= 1'b0;  // rising edge of trigger
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/main_work_ram.sv ====
// no reset on contents; the ram select must already carry cpu_cen, read data lags the address by one clock
`default_nettype none

`include "main_settings.svh"

module main_work_ram (
    input  wire                 clk,
    input  main_pkg::cpu_bus_t  cpu_bus,
    input  main_pkg::chip_sel_t sel,
    output logic [7:0]          ram_dout
);

    logic [7:0]               mem [2**`MAIN_RAM_AW];
    logic [`MAIN_RAM_AW-1:0]  ram_addr;

    assign ram_addr = cpu_bus.addr[`MAIN_RAM_AW-1:0];  // upper bits already decoded

    always_ff @(posedge clk) begin
        if (sel.ram && !cpu_bus.rnw) begin
            mem[ram_addr] <= cpu_bus.dout;
        end
        ram_dout <= mem[ram_addr];  // read every cycle
    end

endmodule

`default_nettype wire

// ==== source/main_read_mux.sv ====
// cpu_din follows the select one clock later; unmapped reads and empty cabinet slots return 8'hff
`default_nettype none

`include "main_settings.svh"

module main_read_mux (
    input  wire                                          clk,
    input  main_pkg::cpu_bus_t                           cpu_bus,
    input  main_pkg::chip_sel_t                          sel,
    input  wire [7:0]                                    rom_data,
    input  wire [7:0]                                    ram_dout,
    input  wire [7:0]                                    vram_dout,
    input  wire [7:0]                                    vscr_dout,
    input  wire [7:0]                                    obj_dout,
    input  wire [7:0]                                    dipsw_a,
    input  wire [7:0]                                    dipsw_b,
    input  main_pkg::sys_sw_t                            sys_sw,
    input  main_pkg::player_t [`MAIN_NUM_PLAYERS-1:0]    players,
    output logic [7:0]                                   cpu_din
);

    logic [7:0] cab_bytes [4];
    logic [7:0] cabinet;

    // slot 0 is the system byte
    assign cab_bytes[0] = {3'b111, sys_sw.start, sys_sw.service, sys_sw.coin};

    for (genvar p = 0; p < 3; p++) begin : g_slot
        if (p < `MAIN_NUM_PLAYERS) begin : g_player
            // directions swapped in pairs on the harness
            assign cab_bytes[p+1] = {2'b11, players[p].joy[5:4],
                                     players[p].joy[2], players[p].joy[3],
                                     players[p].joy[0], players[p].joy[1]};
        end else begin : g_empty
            assign cab_bytes[p+1] = 8'hff;
        end
    end

    assign cabinet = cab_bytes[cpu_bus.addr[6:5]];

    always_ff @(posedge clk) begin
        cpu_din <= sel.rom  ? rom_data  :
                   sel.ram  ? ram_dout  :
                   sel.vram ? vram_dout :
                   sel.vscr ? vscr_dout :
                   sel.obj  ? obj_dout  :
                   sel.ior  ? cabinet   :
                   sel.in6  ? dipsw_a   :
                   sel.in5  ? dipsw_b   : 8'hff;   // open bus
    end

endmodule

`default_nettype wire

// ==== source/main_board.sv ====
// no CPU core here, the bus comes in from outside; ROM latency is left to the external loader
`default_nettype none

`include "main_settings.svh"

module main_board (
    input  wire                                          clk,
    input  wire                                          rst,
    input  main_pkg::cpu_bus_t                           cpu_bus,
    input  wire                                          cpu_cen,
    output logic [7:0]                                   cpu_din,
    // ROM
    output logic [15:0]                                  rom_addr,
    output logic                                         rom_cs,
    input  wire  [7:0]                                   rom_data,
    // video
    output logic                                         vram_cs,
    output logic                                         vscr_cs,
    output logic                                         obj_cs,
    input  wire  [7:0]                                   vram_dout,
    input  wire  [7:0]                                   vscr_dout,
    input  wire  [7:0]                                   obj_dout,
    // sound
    output logic                                         snd_data_cs,
    output logic                                         snd_on_cs,
    // board control
    output logic                                         flip,
    output logic                                         objche,
    output logic [3:0]                                   pal_sel,
    output logic                                         irq_n,
    input  wire                                          LVBL,
    input  wire                                          dip_pause,
    input  wire  [7:0]                                   dipsw_a,
    input  wire  [7:0]                                   dipsw_b,
    // cabinet, active low
    input  main_pkg::player_t [`MAIN_NUM_PLAYERS-1:0]    players,
    input  main_pkg::sys_sw_t                            sys_sw
);

    main_pkg::chip_sel_t                        sel;
    main_pkg::chip_sel_t                        ram_sel;    // ram bit qualified by cpu_cen
    main_pkg::sys_sw_t                          sys_sw_s;
    main_pkg::player_t [`MAIN_NUM_PLAYERS-1:0]  players_s;
    logic [7:0]                                 ram_dout;

    assign rom_addr    = cpu_bus.addr;
    assign rom_cs      = sel.rom;
    assign vram_cs     = sel.vram;
    assign vscr_cs     = sel.vscr;
    assign obj_cs      = sel.obj;
    assign snd_data_cs = sel.snd_data;
    assign snd_on_cs   = sel.snd_on;

    always_comb begin
        ram_sel     = sel;
        ram_sel.ram = sel.ram & cpu_cen;
    end

    main_bus_decoder u_decoder (
        .cpu_bus ( cpu_bus ),
        .sel     ( sel     )
    );

    cabinet_sync #(.payload_t(main_pkg::sys_sw_t)) u_sys_sync (
        .clk  ( clk      ),
        .rst  ( rst      ),
        .din  ( sys_sw   ),
        .dout ( sys_sw_s )
    );

    for (genvar p = 0; p < `MAIN_NUM_PLAYERS; p++) begin : g_player_sync
        cabinet_sync #(.payload_t(main_pkg::player_t)) u_sync (
            .clk  ( clk          ),
            .rst  ( rst          ),
            .din  ( players[p]   ),
            .dout ( players_s[p] )
        );
    end

    main_ctrl_irq u_ctrl (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cpu_cen   ( cpu_cen   ),
        .cpu_bus   ( cpu_bus   ),
        .sel       ( sel       ),
        .lvbl      ( LVBL      ),
        .dip_pause ( dip_pause ),
        .flip      ( flip      ),
        .objche    ( objche    ),
        .irq_n     ( irq_n     ),
        .pal_sel   ( pal_sel   )
    );

    main_work_ram u_ram (
        .clk      ( clk      ),
        .cpu_bus  ( cpu_bus  ),
        .sel      ( ram_sel  ),
        .ram_dout ( ram_dout )
    );

    main_read_mux u_read_mux (
        .clk       ( clk       ),
        .cpu_bus   ( cpu_bus   ),
        .sel       ( sel       ),
        .rom_data  ( rom_data  ),
        .ram_dout  ( ram_dout  ),
        .vram_dout ( vram_dout ),
        .vscr_dout ( vscr_dout ),
        .obj_dout  ( obj_dout  ),
        .dipsw_a   ( dipsw_a   ),
        .dipsw_b   ( dipsw_b   ),
        .sys_sw    ( sys_sw_s  ),
        .players   ( players_s ),
        .cpu_din   ( cpu_din   )
    );

endmodule

`default_nettype wire

// ==== test/main_board_assertions.sv ====
// bound into main_ctrl_irq, so it sees the decoded selects as that block does
`default_nettype none

module main_board_assertions (
    input wire                 clk,
    input wire                 rst,
    input main_pkg::cpu_bus_t  cpu_bus,
    input main_pkg::chip_sel_t sel,
    input wire                 irq_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // never two regions at once
    sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
        else $error("more than one chip select active");

    sel_needs_vma: assert property (@(posedge clk) !cpu_bus.vma |-> sel == '0)
        else $error("chip select active without vma");

    // interrupt released coming out of reset
    irq_after_reset: assert property (@(posedge clk) rst |=> irq_n)
        else $error("irq_n low after reset");

endmodule

bind main_ctrl_irq main_board_assertions u_assertions (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .cpu_bus ( cpu_bus ),
    .sel     ( sel     ),
    .irq_n   ( irq_n   )
);

`default_nettype wire

// ==== test/main_board_tb.sv ====
// random CPU-side testbench; assumes a 4 KB work RAM, 1..3 players and a clock of 10 ns
`default_nettype none

`include "main_settings.svh"

module main_board_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk = 1'b0;
    logic rst;
    logic cpu_cen;
    logic LVBL;
    logic dip_pause;
    main_pkg::cpu_bus_t cpu_bus;
    main_pkg::sys_sw_t sys_sw;
    main_pkg::player_t [`MAIN_NUM_PLAYERS-1:0] players;
    logic [7:0] rom_data, vram_dout, vscr_dout, obj_dout, dipsw_a, dipsw_b;
    logic [7:0] cpu_din;
    logic [15:0] rom_addr;
    logic [3:0] pal_sel;
    logic rom_cs, vram_cs, vscr_cs, obj_cs, snd_data_cs, snd_on_cs;
    logic flip, objche, irq_n;

    integer seed = 32'h2a94f9bd;
    logic [31:0] rnd;
    logic [31:0] src;
    logic [15:0] a;
    logic cen;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int test_err0 = 0;
    logic [7:0] ram_model [4096];
    logic [15:0] addr_q [$];
    logic [7*`MAIN_NUM_PLAYERS-1:0] joy_bits;   // raw joystick lines as driven
    logic flip_m, objche_m, irq_exp;
    logic [3:0] pal_m;

    always #5 clk = ~clk;

    main_board UUT (.*);

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // expected {rom, vram, vscr, obj, snd_data, snd_on}
    function automatic logic [5:0] map_sel(input logic [15:0] ad, input logic rnw, input logic vma);
        logic [5:0] s;
        s = '0;
        if (vma) begin
            s[5] = rnw && (ad >= 16'h6000);
            s[4] = (ad >= 16'h3000) && (ad <= 16'h37ff);
            s[3] = (ad >= 16'h3c30) && (ad <= 16'h3c3f);
            s[2] = (ad >= 16'h3f80) && (ad <= 16'h3fff);
            s[1] = (ad >= 16'h3d00) && (ad <= 16'h3d7f);
            s[0] = (ad >= 16'h3d80) && (ad <= 16'h3dff);
        end
        return s;
    endfunction

    // rom, vram, vscr, obj, or an address that reads as open bus
    function automatic logic [15:0] pass_addr(input logic [31:0] r);
        case (r[18:16])
            3'd0:    return {2'b11, r[13:0]};
            3'd1:    return {3'b011, r[12:0]};
            3'd2:    return {5'b00110, r[10:0]};
            3'd3:    return {12'h3c3, r[3:0]};
            3'd4:    return {9'b0011_1111_1, r[6:0]};
            3'd5:    return {3'b000, r[12:0]};
            3'd6:    return {3'b010, r[12:0]};
            default: return {8'h3d, r[7:0]};    // sound selects read as open bus
        endcase
    endfunction

    function automatic logic [7:0] pass_expect(input logic [15:0] ad, input logic [31:0] s);
        if (ad >= 16'h6000) return s[7:0];
        if (ad >= 16'h3000 && ad <= 16'h37ff) return s[15:8];
        if (ad[15:4] == 12'h3c3) return s[23:16];
        if (ad >= 16'h3f80 && ad <= 16'h3fff) return s[31:24];
        return 8'hff;
    endfunction

    function automatic logic [7:0] cab_expect(input int slot);
        logic [6:0] j;
        if (slot == 0) return {3'b111, sys_sw.start, sys_sw.service, sys_sw.coin};
        if (slot > `MAIN_NUM_PLAYERS) return 8'hff;
        j = joy_bits[7*(slot-1) +: 7];
        return {2'b11, j[5], j[4], j[2], j[3], j[0], j[1]};   // direction pairs swapped
    endfunction

    task automatic put_bus(input logic [15:0] ad, input logic rnw, input logic vma,
                           input logic [7:0] d, input logic ce);
        cpu_bus.addr <= ad;
        cpu_bus.rnw  <= rnw;
        cpu_bus.vma  <= vma;
        cpu_bus.dout <= d;
        cpu_cen      <= ce;
    endtask

    // one bus cycle, returns mid-cycle where outputs are stable
    task automatic drive(input logic [15:0] ad, input logic rnw, input logic vma,
                         input logic [7:0] d, input logic ce);
        @(posedge clk);
        put_bus(ad, rnw, vma, d, ce);
        @(negedge clk);
    endtask

    task automatic check8(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic wait_irq(input logic level, input int limit, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (irq_n !== level && n < limit);
        checks++;
        if (irq_n !== level) begin
            errors++;
            $display("timeout: irq_n did not reach %0b (%s) within %0d clocks", level, what, limit);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: %0d errors", name, errors - test_err0);
        test_err0 = errors;
    endtask

    initial begin
        rst <= 1'b1;
        put_bus(16'h0000, 1'b1, 1'b0, 8'h00, 1'b0);
        {rom_data, vram_dout, vscr_dout, obj_dout} <= '0;
        dipsw_a   <= 8'hff;
        dipsw_b   <= 8'hff;
        sys_sw    <= '1;     // all released
        players   <= '1;
        LVBL      <= 1'b1;
        dip_pause <= 1'b1;
        for (int i = 0; i < 10; i++) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 64; i++) begin
            rnd = next_rand();
            a = {4'h2, rnd[11:0]};
            cen = rnd[24] | rnd[25];
            if (!cen && addr_q.size() > 0) begin
                a = addr_q[rnd[11:0] % addr_q.size()];  // stored byte must survive
            end
            drive(a, 1'b0, 1'b1, rnd[23:16], cen);
            if (cen) begin
                ram_model[a[11:0]] = rnd[23:16];
                addr_q.push_back(a);
            end
        end
        foreach (addr_q[i]) begin
            drive(addr_q[i], 1'b1, 1'b1, 8'h00, 1'b0);
            @(negedge clk);
            @(negedge clk);     // registered RAM plus registered mux
            check8($sformatf("ram read %04h", addr_q[i]), cpu_din, ram_model[addr_q[i][11:0]]);
        end
        end_test("ram");

        for (int i = 0; i < 200; i++) begin
            rnd = next_rand();
            a = rnd[19] ? rnd[15:0] : pass_addr(rnd);
            drive(a, rnd[20], rnd[21] | rnd[22], 8'h00, 1'b0);
            check8($sformatf("selects at %04h", a),
                   {2'b00, rom_cs, vram_cs, vscr_cs, obj_cs, snd_data_cs, snd_on_cs},
                   {2'b00, map_sel(a, rnd[20], rnd[21] | rnd[22])});
            check8($sformatf("rom_addr high at %04h", a), rom_addr[15:8], a[15:8]);
            check8($sformatf("rom_addr low at %04h", a), rom_addr[7:0], a[7:0]);
        end
        end_test("decode");

        for (int i = 0; i < 100; i++) begin
            rnd = next_rand();
            src = next_rand();
            a = pass_addr(rnd);
            @(posedge clk);
            put_bus(a, 1'b1, 1'b1, 8'h00, 1'b0);
            rom_data  <= src[7:0];
            vram_dout <= src[15:8];
            vscr_dout <= src[23:16];
            obj_dout  <= src[31:24];
            @(negedge clk);
            @(negedge clk);
            check8($sformatf("read %04h", a), cpu_din, pass_expect(a, src));
        end
        end_test("pass-through");

        for (int i = 0; i < 12; i++) begin
            rnd = next_rand();
            src = next_rand();
            @(posedge clk);
            joy_bits = rnd[7*`MAIN_NUM_PLAYERS-1:0];
            players <= rnd[7*`MAIN_NUM_PLAYERS-1:0];
            sys_sw  <= src[4:0];
            dipsw_a <= src[15:8];
            dipsw_b <= src[23:16];
            for (int w = 0; w < `MAIN_SYNC_STAGES + 1; w++) @(posedge clk);
            for (int s = 0; s < 4; s++) begin
                a = {9'b0011_1110_0, 2'(s), rnd[28:24]};
                drive(a, 1'b1, 1'b1, 8'h00, 1'b0);
                @(negedge clk);
                check8($sformatf("cabinet slot %0d", s), cpu_din, cab_expect(s));
            end
            drive(16'h3e80, 1'b1, 1'b1, 8'h00, 1'b0);
            @(negedge clk);
            check8("dipsw_b", cpu_din, src[23:16]);
            drive(16'h3f00, 1'b1, 1'b1, 8'h00, 1'b0);
            @(negedge clk);
            check8("dipsw_a", cpu_din, src[15:8]);
        end
        end_test("cabinet");

        flip_m = 1'b0;
        objche_m = 1'b0;
        pal_m = 4'd0;
        for (int i = 0; i < 40; i++) begin
            rnd = next_rand();
            a = rnd[0] ? 16'h3c80 : 16'h3c20;
            cen = rnd[1] | rnd[2];
            drive(a, 1'b0, 1'b1, rnd[15:8], cen);
            if (cen && rnd[0]) begin
                flip_m = rnd[8];
                objche_m = rnd[13];
            end
            if (cen && !rnd[0]) pal_m = rnd[11:8];
            @(negedge clk);
            check8("flip", {7'd0, flip}, {7'd0, flip_m});
            check8("objche", {7'd0, objche}, {7'd0, objche_m});
            check8("pal_sel", {4'd0, pal_sel}, {4'd0, pal_m});
        end
        end_test("control");

        drive(16'h3c80, 1'b0, 1'b1, 8'h02, 1'b1);   // clear latch to 1, irq armed
        @(posedge clk);
        dip_pause <= 1'b1;
        LVBL      <= 1'b0;
        irq_exp = 1'b0;
        wait_irq(irq_exp, 8, "vblank with pause high");
        @(posedge clk);
        LVBL <= 1'b1;
        drive(16'h3c80, 1'b0, 1'b1, 8'h00, 1'b1);
        irq_exp = 1'b1;
        wait_irq(irq_exp, 8, "clear written to 0");
        drive(16'h3c80, 1'b0, 1'b1, 8'h02, 1'b1);
        @(posedge clk);
        dip_pause <= 1'b0;
        LVBL      <= 1'b0;
        for (int w = 0; w < 8; w++) begin
            @(negedge clk);
            check8("irq_n with pause low", {7'd0, irq_n}, {7'd0, irq_exp});
        end
        end_test("interrupt");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
source/main_pkg.sv
source/main_bus_decoder.sv
source/cabinet_sync.sv
source/main_ctrl_irq.sv
source/main_work_ram.sv
source/main_read_mux.sv
source/main_board.sv
test/main_board_assertions.sv
test/main_board_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run main_board_tb with Verilator; pass only when the log holds the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module main_board_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vmain_board_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
exit 1
